// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // integer register width, the word ops assume 64
    localparam int unsigned xlen = 64;

    // register index width
    localparam int unsigned ridx_w = 5;

    // pre-decoded operation codes
    typedef enum logic [5:0] {
        // register forms
        op_add, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        // immediate forms
        op_addi, op_slti, op_sltiu, op_xori, op_ori,
        op_andi, op_slli, op_srli, op_srai,
        // 32-bit results, sign extended
        op_addw, op_subw, op_addiw,
        // upper immediates and jumps
        op_lui, op_auipc, op_jal, op_jalr,
        // conditional branches
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        // loads
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        // stores
        op_sb, op_sh, op_sw, op_sd,
        op_nop
    } op_e;

    // alu function select
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and
    } alu_mode_e;

    // one decoded instruction, imm already generated upstream
    typedef struct packed {
        op_e              op;
        logic [ridx_w-1:0] rd;
        logic [ridx_w-1:0] rs1;
        logic [ridx_w-1:0] rs2;
        logic [xlen-1:0]   imm;
        logic [xlen-1:0]   pc;
    } instr_t;

    // register write, also visible outside as retire
    typedef struct packed {
        logic              wen;
        logic [ridx_w-1:0] rd;
        logic [xlen-1:0]   data;
    } retire_t;

endpackage

`default_nettype wire

// File: rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // memory bus widths
    localparam int unsigned mem_aw = 64;
    localparam int unsigned mem_dw = 64;
    // byte lanes per data word
    localparam int unsigned mem_nb = mem_dw / 8;

    // access size of a load or store
    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word,
        size_double
    } mem_size_e;

    // combinational request, answered in the same cycle
    typedef struct packed {
        logic [mem_aw-1:0] addr;
        // read strobe
        logic              rd;
        logic [mem_dw-1:0] wdata;
        // one bit per byte lane, zero means no write
        logic [mem_nb-1:0] wmask;
    } mem_req_t;

    // one read word, split into lanes by access size
    typedef union packed {
        logic [mem_nb-1:0][7:0]       bytes;
        logic [mem_nb/2-1:0][15:0]    halves;
        logic [mem_nb/4-1:0][31:0]    words;
    } mem_word_u;

endpackage

`default_nettype wire

// File: rtl/exu_regfile.sv
`default_nettype none
`timescale 1ns/1ps

module exu_regfile
    import isa_pkg::*;
#(
    parameter int unsigned num_regs = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [ridx_w-1:0] rs1,
    input  logic [ridx_w-1:0] rs2,
    input  retire_t           wb,
    output logic [xlen-1:0]   src1,
    output logic [xlen-1:0]   src2
);

    logic [xlen-1:0] regs [num_regs];
    logic            wr_ok;

    // x0 and indices past the register count are never written
    assign wr_ok = wb.wen && (wb.rd != '0) && (wb.rd < num_regs);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // combinational reads
    // x0 and missing registers read as zero
    assign src1 = ((rs1 != '0) && (rs1 < num_regs)) ? regs[rs1] : '0;
    assign src2 = ((rs2 != '0) && (rs2 < num_regs)) ? regs[rs2] : '0;

endmodule

`default_nettype wire

// File: rtl/exu_alu.sv
`default_nettype none
`timescale 1ns/1ps

module exu_alu
    import isa_pkg::*;
(
    input  instr_t          instr,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    output logic [xlen-1:0] result
);

    alu_mode_e       mode;
    logic            b_reg;
    logic            word;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [5:0]      shamt;
    logic [xlen-1:0] raw;

    // alu function per op
    // loads, stores, jumps and upper immediates fall through to add
    always_comb begin
        case (instr.op)
            op_sub, op_subw: mode = alu_sub;
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: mode = alu_sub;
            op_sll, op_slli: mode = alu_sll;
            op_srl, op_srli: mode = alu_srl;
            op_sra, op_srai: mode = alu_sra;
            op_slt, op_slti: mode = alu_slt;
            op_sltu, op_sltiu: mode = alu_sltu;
            op_xor, op_xori: mode = alu_xor;
            op_or, op_ori: mode = alu_or;
            op_and, op_andi: mode = alu_and;
            default: mode = alu_add;
        endcase
    end

    // second operand from rs2 for register forms and branches
    assign b_reg = instr.op inside {op_add, op_sub, op_sll, op_slt, op_sltu, op_xor,
                                    op_srl, op_sra, op_or, op_and, op_addw, op_subw,
                                    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};

    // word ops keep the low 32 bits only
    assign word = instr.op inside {op_addw, op_subw, op_addiw};

    // first operand
    always_comb begin
        case (instr.op)
            op_auipc, op_jal: op_a = instr.pc;
            op_lui:           op_a = '0;
            default:          op_a = src1;
        endcase
    end

    assign op_b  = b_reg ? src2 : instr.imm;
    // rv64 shifts use six bits
    assign shamt = op_b[5:0];

    always_comb begin
        case (mode)
            alu_sub:  raw = op_a - op_b;
            alu_sll:  raw = op_a << shamt;
            alu_srl:  raw = op_a >> shamt;
            alu_sra:  raw = $unsigned($signed(op_a) >>> shamt);
            alu_slt:  raw = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: raw = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:  raw = op_a ^ op_b;
            alu_or:   raw = op_a | op_b;
            alu_and:  raw = op_a & op_b;
            default:  raw = op_a + op_b;
        endcase
    end

    // sign extend from bit 31 for the w forms
    assign result = word ? {{(xlen-32){raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

// File: rtl/exu_lsu.sv
`default_nettype none
`timescale 1ns/1ps

module exu_lsu
    import isa_pkg::*;
    import mem_pkg::*;
(
    input  logic            rst,
    input  instr_t          instr,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] src2,
    input  logic [xlen-1:0] mem_rdata,
    output mem_req_t        mem_req,
    output logic [xlen-1:0] load_data
);

    mem_size_e         size;
    logic              is_load;
    logic              is_store;
    logic              sext;
    logic [2:0]        off;
    logic [mem_nb-1:0] base_mask;
    mem_word_u         rword;
    logic [7:0]        lane_b;
    logic [15:0]       lane_h;
    logic [31:0]       lane_w;
    logic [xlen-1:0]   lane;

    // access size from the op
    always_comb begin
        case (instr.op)
            op_lb, op_lbu, op_sb: size = size_byte;
            op_lh, op_lhu, op_sh: size = size_half;
            op_lw, op_lwu, op_sw: size = size_word;
            default:              size = size_double;
        endcase
    end

    assign is_load  = instr.op inside {op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu};
    assign is_store = instr.op inside {op_sb, op_sh, op_sw, op_sd};
    // unsigned loads zero extend
    assign sext     = !(instr.op inside {op_lbu, op_lhu, op_lwu});

    // byte offset in the word, naturally aligned
    // low bits inside the access size are dropped
    always_comb begin
        case (size)
            size_byte: off = addr[2:0];
            size_half: off = {addr[2:1], 1'b0};
            size_word: off = {addr[2], 2'b00};
            default:   off = 3'b000;
        endcase
    end

    // lanes touched before the shift to the offset
    always_comb begin
        case (size)
            size_byte: base_mask = 8'h01;
            size_half: base_mask = 8'h03;
            size_word: base_mask = 8'h0f;
            default:   base_mask = 8'hff;
        endcase
    end

    // request side
    // strobes held low under reset
    always_comb begin
        mem_req.addr  = addr;
        mem_req.rd    = is_load & ~rst;
        mem_req.wdata = is_store ? (src2 << {off, 3'b000}) : '0;
        mem_req.wmask = (is_store & ~rst) ? (base_mask << off) : '0;
    end

    // same read word seen through each lane view
    assign rword  = mem_rdata;
    assign lane_b = rword.bytes[off];
    assign lane_h = rword.halves[off[2:1]];
    assign lane_w = rword.words[off[2]];

    // extension, sign bit only passes for signed loads
    always_comb begin
        case (size)
            size_byte: lane = {{(xlen-8){sext & lane_b[7]}}, lane_b};
            size_half: lane = {{(xlen-16){sext & lane_h[15]}}, lane_h};
            size_word: lane = {{(xlen-32){sext & lane_w[31]}}, lane_w};
            default:   lane = rword;
        endcase
    end

    assign load_data = is_load ? lane : '0;

endmodule

`default_nettype wire

// File: rtl/exu_commit.sv
`default_nettype none
`timescale 1ns/1ps

module exu_commit
    import isa_pkg::*;
(
    input  logic            rst,
    input  instr_t          instr,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,
    input  logic [xlen-1:0] alu_result,
    input  logic [xlen-1:0] load_data,
    output retire_t         retire,
    output logic [xlen-1:0] dnpc
);

    logic [xlen-1:0] snpc;
    logic [xlen-1:0] wdata;
    logic            writes;
    logic            taken;

    // sequential next pc, also the link value
    assign snpc = instr.pc + xlen'(4);

    // branch compare on the source registers
    always_comb begin
        case (instr.op)
            op_beq:  taken = src1 == src2;
            op_bne:  taken = src1 != src2;
            op_blt:  taken = $signed(src1) < $signed(src2);
            op_bge:  taken = $signed(src1) >= $signed(src2);
            op_bltu: taken = src1 < src2;
            op_bgeu: taken = src1 >= src2;
            default: taken = 1'b0;
        endcase
    end

    // next pc
    // jalr target has bit 0 cleared
    always_comb begin
        case (instr.op)
            op_jal:  dnpc = alu_result;
            op_jalr: dnpc = {alu_result[xlen-1:1], 1'b0};
            default: dnpc = taken ? (instr.pc + instr.imm) : snpc;
        endcase
    end

    // writeback source
    always_comb begin
        case (instr.op)
            op_jal, op_jalr: wdata = snpc;
            op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu: wdata = load_data;
            default: wdata = alu_result;
        endcase
    end

    // no write for branches, stores and nop
    // rd of zero still shows on retire
    assign writes = !(instr.op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
                                       op_sb, op_sh, op_sw, op_sd, op_nop});

    always_comb begin
        retire.wen  = writes & ~rst;
        retire.rd   = instr.rd;
        retire.data = wdata;
    end

endmodule

`default_nettype wire

// File: rtl/exu_top.sv
`default_nettype none
`timescale 1ns/1ps

module exu_top
    import isa_pkg::*;
    import mem_pkg::*;
#(
    parameter int unsigned num_regs = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  instr_t          instr,
    input  logic [xlen-1:0] mem_rdata,
    output mem_req_t        mem_req,
    output logic [xlen-1:0] dnpc,
    output retire_t         retire
);

    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] load_data;

    // register read, write back from retire at the next edge
    exu_regfile #(
        .num_regs (num_regs)
    ) regfile_i (
        .clk  (clk),
        .rst  (rst),
        .rs1  (instr.rs1),
        .rs2  (instr.rs2),
        .wb   (retire),
        .src1 (src1),
        .src2 (src2)
    );

    // result, also the load and store address
    exu_alu alu_i (
        .instr  (instr),
        .src1   (src1),
        .src2   (src2),
        .result (alu_result)
    );

    exu_lsu lsu_i (
        .rst       (rst),
        .instr     (instr),
        .addr      (alu_result),
        .src2      (src2),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .load_data (load_data)
    );

    // writeback and next pc
    exu_commit commit_i (
        .rst        (rst),
        .instr      (instr),
        .src1       (src1),
        .src2       (src2),
        .alu_result (alu_result),
        .load_data  (load_data),
        .retire     (retire),
        .dnpc       (dnpc)
    );

endmodule

`default_nettype wire

// File: tb/exu_tb.sv
`default_nettype none
`timescale 1ns/1ps

module exu_tb
    import isa_pkg::*;
    import mem_pkg::*;
();

    // cycles per test phase
    localparam int n_reset = 5;
    localparam int n_zero  = 31;
    localparam int n_seed  = 31;
    localparam int n_alu   = 400;
    localparam int n_word  = 120;
    localparam int n_mem   = 400;
    localparam int n_br    = 160;
    localparam int n_jmp   = 120;
    localparam int n_total = n_reset + n_zero + n_seed + n_alu + n_word + n_mem + n_br + n_jmp;

    logic            clk;
    logic            rst;
    instr_t          instr;
    logic [xlen-1:0] mem_rdata;
    mem_req_t        mem_req;
    logic [xlen-1:0] dnpc;
    retire_t         retire;

    // memory behind the dut, 256 bytes, addresses wrap
    logic [7:0]      mem [256];
    // model copies, updated from predictions only
    logic [7:0]      ref_mem [256];
    logic [xlen-1:0] ref_regs [32];

    exu_top #(
        .num_regs (32)
    ) exu_top_i (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .dnpc      (dnpc),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // aligned 8-byte word around the request address
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            mem_rdata[8*k +: 8] = mem[{mem_req.addr[7:3], 3'(k)}];
        end
    end

    // masked byte writes land at the edge
    always @(posedge clk) begin
        for (int k = 0; k < 8; k++) begin
            if (mem_req.wmask[k]) begin
                mem[{mem_req.addr[7:3], 3'(k)}] <= mem_req.wdata[8*k +: 8];
            end
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // ops of one group sit next to each other in op_e
    function automatic op_e op_in_range(op_e first, op_e last);
        return op_e'(first + ($urandom % (last - first + 1)));
    endfunction

    function automatic int access_bytes(op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return 1;
            op_lh, op_lhu, op_sh: return 2;
            op_lw, op_lwu, op_sw: return 4;
            default:              return 8;
        endcase
    endfunction

    function automatic instr_t make_instr(op_e op);
        instr_t      in;
        logic [63:0] pc;
        logic [11:0] i12;
        logic [19:0] i20;
        pc     = {$urandom, $urandom};
        i12    = 12'($urandom);
        i20    = 20'($urandom);
        in.op  = op;
        in.rd  = 5'($urandom);
        in.rs1 = 5'($urandom);
        in.rs2 = 5'($urandom);
        in.pc  = {pc[63:2], 2'b00};
        case (op)
            op_slli, op_srli, op_srai: in.imm = 64'($urandom % 64);
            op_lui, op_auipc:          in.imm = {{32{i20[19]}}, i20, 12'h000};
            default:                   in.imm = {{52{i12[11]}}, i12};
        endcase
        return in;
    endfunction

    // apply one instruction, predict its effects, compare mid-cycle
    task automatic run_instr(input instr_t in);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] opb;
        logic [63:0] ea;
        logic [63:0] sum;
        logic [63:0] exp_data;
        logic [63:0] exp_npc;
        logic [7:0]  exp_mask;
        logic [7:0]  base;
        logic        exp_wen;
        logic        is_ld;
        logic        is_st;
        logic        taken;
        int          n;
        @(posedge clk);
        instr <= in;
        @(negedge clk);
        a        = ref_regs[in.rs1];
        b        = ref_regs[in.rs2];
        // register forms take rs2, immediate forms take imm
        opb      = (in.op inside {[op_add:op_and], op_addw, op_subw}) ? b : in.imm;
        exp_data = '0;
        exp_npc  = in.pc + 64'd4;
        taken    = 1'b0;
        case (in.op)
            op_add, op_addi:   exp_data = a + opb;
            op_sub:            exp_data = a - opb;
            op_sll, op_slli:   exp_data = a << opb[5:0];
            op_srl, op_srli:   exp_data = a >> opb[5:0];
            op_sra, op_srai:   exp_data = $signed(a) >>> opb[5:0];
            op_slt, op_slti:   exp_data = ($signed(a) < $signed(opb)) ? 64'd1 : 64'd0;
            op_sltu, op_sltiu: exp_data = (a < opb) ? 64'd1 : 64'd0;
            op_xor, op_xori:   exp_data = a ^ opb;
            op_or, op_ori:     exp_data = a | opb;
            op_and, op_andi:   exp_data = a & opb;
            op_addw, op_addiw: begin
                sum      = a + opb;
                exp_data = {{32{sum[31]}}, sum[31:0]};
            end
            op_subw: begin
                sum      = a - opb;
                exp_data = {{32{sum[31]}}, sum[31:0]};
            end
            op_lui:   exp_data = in.imm;
            op_auipc: exp_data = in.pc + in.imm;
            op_jal: begin
                exp_data = in.pc + 64'd4;
                exp_npc  = in.pc + in.imm;
            end
            op_jalr: begin
                exp_data = in.pc + 64'd4;
                exp_npc  = (a + in.imm) & ~64'd1;
            end
            op_beq:  taken = a == b;
            op_bne:  taken = a != b;
            op_blt:  taken = $signed(a) < $signed(b);
            op_bge:  taken = $signed(a) >= $signed(b);
            op_bltu: taken = a < b;
            op_bgeu: taken = a >= b;
            default: ;
        endcase
        if (taken) begin
            exp_npc = in.pc + in.imm;
        end
        exp_wen = !(in.op inside {[op_beq:op_bgeu], [op_sb:op_sd], op_nop});
        // memory side, naturally aligned inside the access size
        is_ld = in.op inside {[op_lb:op_lwu]};
        is_st = in.op inside {[op_sb:op_sd]};
        ea    = a + in.imm;
        n     = access_bytes(in.op);
        base  = ea[7:0] & ~8'(n - 1);
        if (is_ld) begin
            for (int k = 0; k < n; k++) begin
                exp_data[8*k +: 8] = ref_mem[8'(base + k)];
            end
            // signed loads copy the top bit of the value upward
            if (!(in.op inside {op_lbu, op_lhu, op_lwu}) && n < 8 && exp_data[8*n-1]) begin
                exp_data = exp_data | ~((64'd1 << (8*n)) - 64'd1);
            end
        end
        exp_mask = is_st ? 8'(((1 << n) - 1) << base[2:0]) : 8'h00;
        check_value("retire.wen", retire.wen, exp_wen);
        check_value("retire.rd", retire.rd, in.rd);
        if (exp_wen) begin
            check_value("retire.data", retire.data, exp_data);
        end
        check_value("dnpc", dnpc, exp_npc);
        check_value("mem_req.rd", mem_req.rd, is_ld);
        check_value("mem_req.wmask", mem_req.wmask, exp_mask);
        if (is_ld || is_st) begin
            check_value("mem_req.addr", mem_req.addr, ea);
        end
        if (is_st) begin
            check_value("mem_req.wdata", mem_req.wdata, b << (8 * base[2:0]));
            for (int k = 0; k < n; k++) begin
                ref_mem[8'(base + k)] = b[8*k +: 8];
            end
        end
        // x0 stays zero in the model
        if (exp_wen && in.rd != '0) begin
            ref_regs[in.rd] = exp_data;
        end
    endtask

    // watchdog, one cycle per instruction plus margin
    initial begin
        #((n_total + 20) * 8);
        $display("Finished with errors");
        $fatal(1, "timeout: tests did not complete within %0d cycles", n_total + 20);
    end

    initial begin
        instr_t t;
        void'($urandom(32'hb789));
        rst   = 1'b1;
        instr = make_instr(op_nop);
        for (int i = 0; i < 256; i++) begin
            mem[i]     = 8'($urandom);
            ref_mem[i] = mem[i];
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        // memory ops under reset, strobes and wen must stay low
        repeat (n_reset) begin
            @(posedge clk);
            instr <= make_instr(op_in_range(op_lb, op_sd));
            @(negedge clk);
            check_value("retire.wen", retire.wen, 1'b0);
            check_value("mem_req.rd", mem_req.rd, 1'b0);
            check_value("mem_req.wmask", mem_req.wmask, 8'h00);
        end
        @(posedge clk);
        rst   <= 1'b0;
        instr <= make_instr(op_nop);
        // every register reads zero after reset
        for (int i = 1; i < 32; i++) begin
            t     = make_instr(op_or);
            t.rd  = '0;
            t.rs1 = 5'(i);
            t.rs2 = '0;
            run_instr(t);
        end
        // fill the registers with random values
        for (int i = 1; i < 32; i++) begin
            t     = make_instr(op_lui);
            t.rd  = 5'(i);
            t.imm = {$urandom, $urandom};
            run_instr(t);
        end
        repeat (n_alu) begin
            run_instr(make_instr(op_in_range(op_add, op_srai)));
        end
        repeat (n_word) begin
            run_instr(make_instr(op_in_range(op_addw, op_addiw)));
        end
        // loads and stores mixed so loads see earlier stores
        repeat (n_mem) begin
            run_instr(make_instr(op_in_range(op_lb, op_sd)));
        end
        repeat (n_br) begin
            t = make_instr(op_in_range(op_beq, op_bgeu));
            // equal operands now and then
            if ($urandom % 4 == 0) begin
                t.rs2 = t.rs1;
            end
            run_instr(t);
        end
        repeat (n_jmp) begin
            run_instr(make_instr(op_in_range(op_lui, op_jalr)));
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
rtl/isa_pkg.sv
rtl/mem_pkg.sv
rtl/exu_regfile.sv
rtl/exu_alu.sv
rtl/exu_lsu.sv
rtl/exu_commit.sv
rtl/exu_top.sv
tb/exu_tb.sv

// File: Bender.yml
package:
  name: exu

sources:
  - files:
      - rtl/isa_pkg.sv
      - rtl/mem_pkg.sv
      - rtl/exu_regfile.sv
      - rtl/exu_alu.sv
      - rtl/exu_lsu.sv
      - rtl/exu_commit.sv
      - rtl/exu_top.sv
  - target: test
    files:
      - tb/exu_tb.sv
